// File: orderBookDir_consts.svh
`ifndef ORDER_BOOK_DIR_CONSTS_SVH
`define ORDER_BOOK_DIR_CONSTS_SVH

// bytes in one feed word
`define WORD_BYTES 8

// width of input and realigned words
`define WORD_BITS (`WORD_BYTES * 8)

// aligned words kept from one directory message
`define MSG_WORDS 7

// byte position of the message start inside the first word
`define OFFSET_BITS 3

`endif

// File: orderBookDirPkg.sv
`default_nettype none

`include "orderBookDir_consts.svh"

package orderBookDirPkg;

    typedef enum logic {
        IDLE,
        RUN
    } alignState_t;

    // position of an aligned word inside the message
    typedef enum logic [2:0] {
        W_HEADER  = 3'd0,
        W_SYMBOL  = 3'd1,
        W_ISIN_LO = 3'd2,
        W_ISIN_HI = 3'd3,
        W_SIZES   = 3'd4,
        W_LOTS    = 3'd5,
        W_NOMINAL = 3'd6
    } dirWord_e;

    typedef struct packed {
        logic [31:0]             timeStamp;
        logic [31:0]             orderBookId;
        logic [`WORD_BITS-1:0]   symbol;
        logic [95:0]             isin;
    } identityFields_t;

    typedef struct packed {
        logic [7:0]              financialProduct;
        logic [23:0]             tradingCurrency;
        logic [15:0]             decimalsInPrice;
        logic [15:0]             decimalsInNominalValue;
        logic [31:0]             oddLotSize;
        logic [31:0]             roundLotSize;
        logic [31:0]             blockLotSize;
        logic [`WORD_BITS-1:0]   nominalValue;
    } tradingFields_t;

endpackage

`default_nettype wire

// File: wordAligner.sv
`timescale 1ns/1ps
`default_nettype none

`include "orderBookDir_consts.svh"

module wordAligner
    import orderBookDirPkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic [`WORD_BITS-1:0]   dataIn,
    input  wire logic                    wordValid,
    input  wire logic                    start,
    input  wire logic [`OFFSET_BITS-1:0] startOffset,
    output logic                         alignedValid,
    output logic [`WORD_BITS-1:0]        alignedWord,
    output dirWord_e                     alignedIndex
);

    localparam dirWord_e lastWord = dirWord_e'(`MSG_WORDS - 1);

    alignState_t state;
    dirWord_e wordIndex;
    logic [`OFFSET_BITS-1:0] offset;
    logic [`WORD_BITS-1:0] heldWord;
    logic [`WORD_BITS-1:0] joinedWord;
    logic [5:0] lowShift;
    logic [6:0] highShift;
    logic loadFirst;
    logic emitFirst;
    logic runBeat;

    assign loadFirst = (state == IDLE) && start && wordValid;
    assign emitFirst = loadFirst && (startOffset == '0);
    assign runBeat = (state == RUN) && wordValid;

    // upper bytes of the held word, low bytes of the new one on top
    always_comb begin
        lowShift = {offset, 3'b000};
        highShift = 7'(`WORD_BITS) - {1'b0, lowShift};
        if (offset == '0) begin
            joinedWord = dataIn;
        end else begin
            joinedWord = (heldWord >> lowShift) | (dataIn << highShift);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            wordIndex <= W_HEADER;
            alignedValid <= 1'b0;
        end else begin
            alignedValid <= emitFirst || runBeat;
            if (loadFirst) begin
                state <= RUN;
                // offset 0 sends the header straight through
                if (startOffset == '0) begin
                    wordIndex <= W_SYMBOL;
                end
            end else if (runBeat) begin
                if (wordIndex == lastWord) begin
                    state <= IDLE;
                    wordIndex <= W_HEADER;
                end else begin
                    wordIndex <= dirWord_e'(wordIndex + 3'd1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (loadFirst) begin
            offset <= startOffset;
        end
        if (loadFirst || runBeat) begin
            heldWord <= dataIn;
        end
        if (emitFirst || runBeat) begin
            alignedWord <= emitFirst ? dataIn : joinedWord;
            alignedIndex <= wordIndex;
        end
    end

endmodule

`default_nettype wire

// File: identityFieldCapture.sv
`timescale 1ns/1ps
`default_nettype none

`include "orderBookDir_consts.svh"

module identityFieldCapture
    import orderBookDirPkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  alignedValid,
    input  wire logic [`WORD_BITS-1:0] alignedWord,
    input  wire dirWord_e              alignedIndex,
    output identityFields_t            fields,
    output logic                       complete
);

    always_ff @(posedge clk) begin
        if (rst) begin
            complete <= 1'b0;
        end else begin
            complete <= alignedValid && (alignedIndex == W_ISIN_HI);
        end
    end

    always_ff @(posedge clk) begin
        if (alignedValid) begin
            case (alignedIndex)
                W_HEADER: begin
                    fields.timeStamp <= alignedWord[31:0];
                    fields.orderBookId <= alignedWord[63:32];
                end
                W_SYMBOL: begin
                    fields.symbol <= alignedWord;
                end
                W_ISIN_LO: begin
                    fields.isin[63:0] <= alignedWord;
                end
                // upper half of this word belongs to the trading side
                W_ISIN_HI: begin
                    fields.isin[95:64] <= alignedWord[31:0];
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: tradingFieldCapture.sv
`timescale 1ns/1ps
`default_nettype none

`include "orderBookDir_consts.svh"

module tradingFieldCapture
    import orderBookDirPkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  alignedValid,
    input  wire logic [`WORD_BITS-1:0] alignedWord,
    input  wire dirWord_e              alignedIndex,
    output tradingFields_t             fields,
    output logic                       complete
);

    always_ff @(posedge clk) begin
        if (rst) begin
            complete <= 1'b0;
        end else begin
            complete <= alignedValid && (alignedIndex == W_NOMINAL);
        end
    end

    always_ff @(posedge clk) begin
        if (alignedValid) begin
            case (alignedIndex)
                // product and currency share the word with the isin tail
                W_ISIN_HI: begin
                    fields.financialProduct <= alignedWord[39:32];
                    fields.tradingCurrency <= alignedWord[63:40];
                end
                W_SIZES: begin
                    fields.decimalsInPrice <= alignedWord[15:0];
                    fields.decimalsInNominalValue <= alignedWord[31:16];
                    fields.oddLotSize <= alignedWord[63:32];
                end
                W_LOTS: begin
                    fields.roundLotSize <= alignedWord[31:0];
                    fields.blockLotSize <= alignedWord[63:32];
                end
                W_NOMINAL: begin
                    fields.nominalValue <= alignedWord;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: directoryRecordAssembler.sv
`timescale 1ns/1ps
`default_nettype none

module directoryRecordAssembler
    import orderBookDirPkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire identityFields_t identity,
    input  wire logic            identityComplete,
    input  wire tradingFields_t  trading,
    input  wire logic            tradingComplete,
    output identityFields_t      identityOut,
    output tradingFields_t       tradingOut,
    output logic                 recordValid
);

    // identity half of the current message is in
    logic identityDone;
    logic loadRecord;

    assign loadRecord = tradingComplete && identityDone;

    always_ff @(posedge clk) begin
        if (rst) begin
            identityDone <= 1'b0;
            recordValid <= 1'b0;
            identityOut <= '0;
            tradingOut <= '0;
        end else begin
            recordValid <= loadRecord;
            if (identityComplete) begin
                identityDone <= 1'b1;
            end else if (loadRecord) begin
                identityDone <= 1'b0;
            end
            if (loadRecord) begin
                identityOut <= identity;
                tradingOut <= trading;
            end
        end
    end

endmodule

`default_nettype wire

// File: orderBookDirectoryParser.sv
`timescale 1ns/1ps
`default_nettype none

`include "orderBookDir_consts.svh"

module orderBookDirectoryParser
    import orderBookDirPkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic [`WORD_BITS-1:0]   dataIn,
    input  wire logic                    wordValid,
    input  wire logic                    start,
    input  wire logic [`OFFSET_BITS-1:0] startOffset,
    output logic                         recordValid,
    output logic [31:0]                  timeStamp,
    output logic [31:0]                  orderBookId,
    output logic [`WORD_BITS-1:0]        symbol,
    output logic [95:0]                  isin,
    output logic [7:0]                   financialProduct,
    output logic [23:0]                  tradingCurrency,
    output logic [15:0]                  decimalsInPrice,
    output logic [15:0]                  decimalsInNominalValue,
    output logic [31:0]                  oddLotSize,
    output logic [31:0]                  roundLotSize,
    output logic [31:0]                  blockLotSize,
    output logic [`WORD_BITS-1:0]        nominalValue
);

    logic alignedValid;
    logic [`WORD_BITS-1:0] alignedWord;
    dirWord_e alignedIndex;
    identityFields_t identity;
    identityFields_t identityOut;
    tradingFields_t trading;
    tradingFields_t tradingOut;
    logic identityComplete;
    logic tradingComplete;

    wordAligner alignerInst (
        .clk          (clk),
        .rst          (rst),
        .dataIn       (dataIn),
        .wordValid    (wordValid),
        .start        (start),
        .startOffset  (startOffset),
        .alignedValid (alignedValid),
        .alignedWord  (alignedWord),
        .alignedIndex (alignedIndex)
    );

    // the two capture units see the same aligned stream
    identityFieldCapture identityInst (
        .clk          (clk),
        .rst          (rst),
        .alignedValid (alignedValid),
        .alignedWord  (alignedWord),
        .alignedIndex (alignedIndex),
        .fields       (identity),
        .complete     (identityComplete)
    );

    tradingFieldCapture tradingInst (
        .clk          (clk),
        .rst          (rst),
        .alignedValid (alignedValid),
        .alignedWord  (alignedWord),
        .alignedIndex (alignedIndex),
        .fields       (trading),
        .complete     (tradingComplete)
    );

    directoryRecordAssembler assemblerInst (
        .clk              (clk),
        .rst              (rst),
        .identity         (identity),
        .identityComplete (identityComplete),
        .trading          (trading),
        .tradingComplete  (tradingComplete),
        .identityOut      (identityOut),
        .tradingOut       (tradingOut),
        .recordValid      (recordValid)
    );

    assign timeStamp = identityOut.timeStamp;
    assign orderBookId = identityOut.orderBookId;
    assign symbol = identityOut.symbol;
    assign isin = identityOut.isin;
    assign financialProduct = tradingOut.financialProduct;
    assign tradingCurrency = tradingOut.tradingCurrency;
    assign decimalsInPrice = tradingOut.decimalsInPrice;
    assign decimalsInNominalValue = tradingOut.decimalsInNominalValue;
    assign oddLotSize = tradingOut.oddLotSize;
    assign roundLotSize = tradingOut.roundLotSize;
    assign blockLotSize = tradingOut.blockLotSize;
    assign nominalValue = tradingOut.nominalValue;

endmodule

`default_nettype wire

// File: tbOrderBookDirectoryParser.sv
`timescale 1ns/1ps
`default_nettype none

`include "orderBookDir_consts.svh"

module tbOrderBookDirectoryParser;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_ROWS = 12;
    localparam int NUM_FIELDS = 12;
    localparam int MSG_BYTES = `MSG_WORDS * `WORD_BYTES;
    localparam int MAX_GAP = 3;
    localparam int WAIT_LIMIT = 20;
    // eight beats per row, each stretched by the worst gap, plus slack
    localparam int WATCHDOG_NS = (NUM_ROWS * 8 * (MAX_GAP + 4) + 200) * CLK_PERIOD;

    typedef struct packed {
        logic [`OFFSET_BITS-1:0] offset;
        logic                    gaps;
        logic                    resetMid;
        logic                    extraStart;
    } testRow_t;

    string testNames [NUM_ROWS] = '{
        "aligned", "offset1", "offset2", "offset3", "offset4", "offset5",
        "offset6", "offset7", "gapsOffset0", "gapsOffset5", "resetMidway", "extraStart"
    };

    testRow_t testTable [NUM_ROWS] = '{
        '{3'd0, 1'b0, 1'b0, 1'b0},
        '{3'd1, 1'b0, 1'b0, 1'b0},
        '{3'd2, 1'b0, 1'b0, 1'b0},
        '{3'd3, 1'b0, 1'b0, 1'b0},
        '{3'd4, 1'b0, 1'b0, 1'b0},
        '{3'd5, 1'b0, 1'b0, 1'b0},
        '{3'd6, 1'b0, 1'b0, 1'b0},
        '{3'd7, 1'b0, 1'b0, 1'b0},
        '{3'd0, 1'b1, 1'b0, 1'b0},
        '{3'd5, 1'b1, 1'b0, 1'b0},
        '{3'd3, 1'b0, 1'b1, 1'b0},
        '{3'd6, 1'b1, 1'b0, 1'b1}
    };

    string fieldNames [NUM_FIELDS] = '{
        "timeStamp", "orderBookId", "symbol", "isin", "financialProduct",
        "tradingCurrency", "decimalsInPrice", "decimalsInNominalValue",
        "oddLotSize", "roundLotSize", "blockLotSize", "nominalValue"
    };

    logic clk = 1'b0;
    logic rst;
    logic [`WORD_BITS-1:0] dataIn;
    logic wordValid;
    logic start;
    logic [`OFFSET_BITS-1:0] startOffset;
    logic recordValid;
    logic [31:0] timeStamp;
    logic [31:0] orderBookId;
    logic [`WORD_BITS-1:0] symbol;
    logic [95:0] isin;
    logic [7:0] financialProduct;
    logic [23:0] tradingCurrency;
    logic [15:0] decimalsInPrice;
    logic [15:0] decimalsInNominalValue;
    logic [31:0] oddLotSize;
    logic [31:0] roundLotSize;
    logic [31:0] blockLotSize;
    logic [`WORD_BITS-1:0] nominalValue;

    logic [7:0] msgBytes [MSG_BYTES];
    logic [`WORD_BITS-1:0] beatWords [8];
    logic [95:0] expField [NUM_FIELDS];
    logic [95:0] prevField [NUM_FIELDS];
    logic [95:0] actField [NUM_FIELDS];
    int numBeats;
    int errorCount = 0;
    int missingCount = 0;

    orderBookDirectoryParser dut_i (
        .clk                    (clk),
        .rst                    (rst),
        .dataIn                 (dataIn),
        .wordValid              (wordValid),
        .start                  (start),
        .startOffset            (startOffset),
        .recordValid            (recordValid),
        .timeStamp              (timeStamp),
        .orderBookId            (orderBookId),
        .symbol                 (symbol),
        .isin                   (isin),
        .financialProduct       (financialProduct),
        .tradingCurrency        (tradingCurrency),
        .decimalsInPrice        (decimalsInPrice),
        .decimalsInNominalValue (decimalsInNominalValue),
        .oddLotSize             (oddLotSize),
        .roundLotSize           (roundLotSize),
        .blockLotSize           (blockLotSize),
        .nominalValue           (nominalValue)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign actField[0] = 96'(timeStamp);
    assign actField[1] = 96'(orderBookId);
    assign actField[2] = 96'(symbol);
    assign actField[3] = isin;
    assign actField[4] = 96'(financialProduct);
    assign actField[5] = 96'(tradingCurrency);
    assign actField[6] = 96'(decimalsInPrice);
    assign actField[7] = 96'(decimalsInNominalValue);
    assign actField[8] = 96'(oddLotSize);
    assign actField[9] = 96'(roundLotSize);
    assign actField[10] = 96'(blockLotSize);
    assign actField[11] = 96'(nominalValue);

    task automatic checkValue(input string testName, input string what,
                              input logic [95:0] expected, input logic [95:0] actual);
        if (expected !== actual) begin
            errorCount++;
            $display("CHECK FAILED %s %s: expected %0h, actual %0h",
                     testName, what, expected, actual);
        end
    endtask

    // little-endian value of a byte run inside the message
    function automatic logic [95:0] leValue(int first, int count);
        logic [95:0] value;
        value = '0;
        for (int i = count - 1; i >= 0; i--) begin
            value = {value[87:0], msgBytes[first + i]};
        end
        return value;
    endfunction

    task automatic idleInputs();
        dataIn = {$urandom, $urandom};
        wordValid = 1'b0;
        start = 1'b0;
        startOffset = 3'($urandom);
    endtask

    // outside a pulse the record must stay as it was
    task automatic holdCheck(input string testName);
        checkValue(testName, "recordValid", 96'(0), 96'(recordValid));
        for (int f = 0; f < NUM_FIELDS; f++) begin
            checkValue(testName, fieldNames[f], prevField[f], actField[f]);
        end
    endtask

    task automatic packMessage(input logic [`OFFSET_BITS-1:0] offset);
        logic [7:0] stream [64];
        for (int i = 0; i < 64; i++) begin
            stream[i] = 8'($urandom);
        end
        for (int i = 0; i < MSG_BYTES; i++) begin
            msgBytes[i] = 8'($urandom);
            stream[int'(offset) + i] = msgBytes[i];
        end
        numBeats = (offset == 3'd0) ? `MSG_WORDS : `MSG_WORDS + 1;
        for (int w = 0; w < 8; w++) begin
            for (int b = 0; b < 8; b++) begin
                beatWords[w][8*b +: 8] = stream[8*w + b];
            end
        end
        // byte layout of the seven aligned words
        expField[0] = leValue(0, 4);
        expField[1] = leValue(4, 4);
        expField[2] = leValue(8, 8);
        expField[3] = leValue(16, 12);
        expField[4] = leValue(28, 1);
        expField[5] = leValue(29, 3);
        expField[6] = leValue(32, 2);
        expField[7] = leValue(34, 2);
        expField[8] = leValue(36, 4);
        expField[9] = leValue(40, 4);
        expField[10] = leValue(44, 4);
        expField[11] = leValue(48, 8);
    endtask

    task automatic sendBeats(input string testName, input testRow_t row, input int beatCount);
        int gap;
        for (int b = 0; b < beatCount; b++) begin
            gap = row.gaps ? int'($urandom_range(0, MAX_GAP)) : 0;
            for (int g = 0; g < gap; g++) begin
                @(negedge clk);
                holdCheck(testName);
                idleInputs();
            end
            @(negedge clk);
            holdCheck(testName);
            dataIn = beatWords[b];
            wordValid = 1'b1;
            // a second start inside the message must be ignored
            start = (b == 0) || (row.extraStart && b == 2);
            startOffset = (b == 0) ? row.offset : row.offset + 3'd3;
        end
    endtask

    task automatic awaitRecord(input string testName);
        int cycles;
        cycles = 0;
        while (cycles < WAIT_LIMIT) begin
            @(negedge clk);
            idleInputs();
            cycles++;
            if (recordValid === 1'b1) begin
                break;
            end
            holdCheck(testName);
        end
        if (recordValid !== 1'b1) begin
            missingCount++;
            $display("no recordValid pulse for test %s within %0d cycles", testName, WAIT_LIMIT);
        end else begin
            checkValue(testName, "latency", 96'(3), 96'(cycles));
            for (int f = 0; f < NUM_FIELDS; f++) begin
                checkValue(testName, fieldNames[f], expField[f], actField[f]);
                prevField[f] = expField[f];
            end
        end
    endtask

    initial begin
        void'($urandom(32'h3588b1d3));
        rst = 1'b1;
        idleInputs();
        for (int f = 0; f < NUM_FIELDS; f++) begin
            prevField[f] = '0;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (testTable[r].resetMid) begin
                // half a message, then reset drops it
                packMessage(testTable[r].offset);
                sendBeats(testNames[r], testTable[r], 4);
                @(negedge clk);
                idleInputs();
                rst = 1'b1;
                for (int f = 0; f < NUM_FIELDS; f++) begin
                    prevField[f] = '0;
                end
                repeat (4) begin
                    @(negedge clk);
                    holdCheck(testNames[r]);
                end
                rst = 1'b0;
            end
            packMessage(testTable[r].offset);
            sendBeats(testNames[r], testTable[r], numBeats);
            awaitRecord(testNames[r]);
        end
        // the last record has to stay a single pulse as well
        repeat (4) begin
            @(negedge clk);
            holdCheck(testNames[NUM_ROWS - 1]);
        end
        $display("errors: %0d value mismatches, %0d missing records", errorCount, missingCount);
        if (errorCount == 0 && missingCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before all tests finished", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
orderBookDirPkg.sv
wordAligner.sv
identityFieldCapture.sv
tradingFieldCapture.sv
directoryRecordAssembler.sv
orderBookDirectoryParser.sv
tbOrderBookDirectoryParser.sv

// File: runSim.sh
#!/usr/bin/env bash
# build and run the parser testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tbOrderBookDirectoryParser -o simParser
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/simParser)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation run failed"
    exit 1
fi

if echo "$output" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1
